//--- rtl/fv_cfg_pkg.sv
// feature-value bank configuration
// sizes of the bank and widths of the address fields
package fv_cfg_pkg;

    // one feature line and the node layout
    localparam int FV_LINE_W         = 64;
    localparam int FV_LINES_PER_NODE = 4;
    localparam int FV_NODES          = 64;

    // replay iteration grouping
    localparam int FV_NODES_PER_ITER = 8;
    localparam int FV_ITERS          = FV_NODES / FV_NODES_PER_ITER;

    // total lines held by the SRAM
    localparam int FV_DEPTH = FV_NODES * FV_LINES_PER_NODE;

    // field widths
    localparam int FV_LINE_IDX_W  = $clog2(FV_LINES_PER_NODE);
    localparam int FV_NODE_W      = $clog2(FV_NODES);
    localparam int FV_ITER_W      = $clog2(FV_ITERS);
    localparam int FV_ITER_NODE_W = $clog2(FV_NODES_PER_ITER);
    localparam int FV_ADDR_W      = $clog2(FV_DEPTH);
    localparam int FV_ITER_LINE_W = $clog2(FV_NODES_PER_ITER * FV_LINES_PER_NODE);

    // edge PE tag
    localparam int FV_PE_TAG_W = 2;

endpackage

//--- rtl/fv_pkt_pkg.sv
// feature-value bank packet formats
// request beat, stream beat to the small bank and edge PE beat
package fv_pkt_pkg;

    import fv_cfg_pkg::*;

    // request operation
    typedef enum logic [1:0] {
        op_write  = 2'd0,
        op_read   = 2'd1,
        op_stream = 2'd2
    } fv_op_t;

    // one request beat
    // last only matters for write bursts
    typedef struct packed {
        fv_op_t                 op;
        logic [FV_NODE_W-1:0]   node_id;
        logic [FV_ITER_W-1:0]   iter;
        logic [FV_PE_TAG_W-1:0] pe_tag;
        logic [FV_LINE_W-1:0]   data;
        logic                   last;
    } fv_req_t;

    // beat towards the small feature bank
    typedef struct packed {
        logic                      sos;
        logic                      eos;
        logic [FV_ITER_LINE_W-1:0] iter_line;
        logic [FV_LINE_W-1:0]      data;
    } fv_stream_beat_t;

    // beat back to an edge PE
    typedef struct packed {
        logic                   sos;
        logic                   eos;
        logic [FV_PE_TAG_W-1:0] pe_tag;
        logic [FV_LINE_W-1:0]   data;
    } fv_edge_beat_t;

endpackage

//--- rtl/fv_sram.sv
// single-port feature line memory
// one cycle read latency, behavioural model
`timescale 1ns/10ps

module fv_sram (
    input  logic                             clk,
    input  logic                             en,
    input  logic                             we,
    input  logic [fv_cfg_pkg::FV_ADDR_W-1:0] addr,
    input  logic [fv_cfg_pkg::FV_LINE_W-1:0] wdata,
    output logic [fv_cfg_pkg::FV_LINE_W-1:0] rdata
);

    import fv_cfg_pkg::*;

    logic [FV_LINE_W-1:0] mem [FV_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // read data is held until the next read
                rdata <= mem[addr];
            end
        end
    end

    a_addr_known: assert property (@(posedge clk)
        en |-> !$isunknown(addr));

endmodule

//--- rtl/fv_beat_counter.sv
// line and node counter for bursts and iteration streams
`timescale 1ns/10ps

module fv_beat_counter (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  clear,
    input  logic                                  step,
    output logic [fv_cfg_pkg::FV_LINE_IDX_W-1:0]  line_idx,
    output logic [fv_cfg_pkg::FV_ITER_NODE_W-1:0] node_idx,
    output logic                                  last_line,
    output logic                                  last_node
);

    import fv_cfg_pkg::*;

    assign last_line = (line_idx == FV_LINE_IDX_W'(FV_LINES_PER_NODE - 1));
    assign last_node = (node_idx == FV_ITER_NODE_W'(FV_NODES_PER_ITER - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            line_idx <= '0;
            node_idx <= '0;
        end else if (clear) begin
            line_idx <= '0;
            node_idx <= '0;
        end else if (step) begin
            if (last_line) begin
                line_idx <= '0;
                // carry into the node count
                if (last_node) begin
                    node_idx <= '0;
                end else begin
                    node_idx <= node_idx + 1'b1;
                end
            end else begin
                line_idx <= line_idx + 1'b1;
            end
        end
    end

    // the controller must clear at the end of an iteration, never step past it
    a_no_step_past_end: assert property (@(posedge clk) disable iff (reset)
        (last_line && last_node && step) |-> clear);

endmodule

//--- rtl/fv_out_stage.sv
// output pipeline of the bank
// carries the beat tag past the SRAM read and fills in the line data
`timescale 1ns/10ps

module fv_out_stage #(
    parameter type beat_t = fv_pkt_pkg::fv_edge_beat_t
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             tag_valid,
    input  beat_t                            tag,
    input  logic [fv_cfg_pkg::FV_LINE_W-1:0] rdata,
    output logic                             out_valid,
    output beat_t                            out_beat
);

    // tag waiting for the SRAM
    logic  s1_valid;
    beat_t s1_beat;

    // tag with the read line filled in
    beat_t merged;

    always_comb begin
        merged      = s1_beat;
        merged.data = rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= tag_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_beat  <= tag;
        out_beat <= merged;
    end

endmodule

//--- rtl/fv_bank_fsm.sv
// feature-value bank controller
// accepts write, read and stream requests and sequences the SRAM accesses
`timescale 1ns/10ps

module fv_bank_fsm (
    input  logic                                  clk,
    input  logic                                  reset,
    input  fv_pkt_pkg::fv_req_t                   req,
    input  logic                                  req_valid,
    input  logic [fv_cfg_pkg::FV_LINE_IDX_W-1:0]  line_idx,
    input  logic [fv_cfg_pkg::FV_ITER_NODE_W-1:0] node_idx,
    input  logic                                  last_line,
    input  logic                                  last_node,
    output logic                                  req_ready,
    output logic                                  mem_en,
    output logic                                  mem_we,
    output logic [fv_cfg_pkg::FV_ADDR_W-1:0]      mem_addr,
    output logic [fv_cfg_pkg::FV_LINE_W-1:0]      mem_wdata,
    output logic                                  cnt_clear,
    output logic                                  cnt_step,
    output logic                                  stream_tag_valid,
    output fv_pkt_pkg::fv_stream_beat_t           stream_tag,
    output logic                                  edge_tag_valid,
    output fv_pkt_pkg::fv_edge_beat_t             edge_tag
);

    import fv_cfg_pkg::*;
    import fv_pkt_pkg::*;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_write  = 2'd1,
        st_read   = 2'd2,
        st_stream = 2'd3
    } state_t;

    state_t state;
    state_t state_next;

    logic                   accept;
    logic [FV_NODE_W-1:0]   node_q;
    logic [FV_ITER_W-1:0]   iter_q;
    logic [FV_PE_TAG_W-1:0] tag_q;

    // requests only in idle and between write beats
    assign req_ready = (state == st_idle) || (state == st_write);
    assign accept    = req_valid && req_ready;

    // write data comes straight from the request beat
    assign mem_wdata = req.data;

    always_comb begin
        state_next       = state;
        mem_en           = 1'b0;
        mem_we           = 1'b0;
        mem_addr         = '0;
        cnt_clear        = 1'b0;
        cnt_step         = 1'b0;
        stream_tag_valid = 1'b0;
        stream_tag       = '0;
        edge_tag_valid   = 1'b0;
        edge_tag         = '0;

        case (state)
            st_idle: begin
                if (accept) begin
                    case (req.op)
                        op_write: begin
                            // first beat lands on line 0 at once
                            mem_en   = 1'b1;
                            mem_we   = 1'b1;
                            mem_addr = {req.node_id, {FV_LINE_IDX_W{1'b0}}};
                            if (!req.last) begin
                                cnt_step   = 1'b1;
                                state_next = st_write;
                            end
                        end
                        op_read:   state_next = st_read;
                        op_stream: state_next = st_stream;
                        default:   state_next = st_idle;
                    endcase
                end
            end

            st_write: begin
                if (accept) begin
                    mem_en   = 1'b1;
                    mem_we   = 1'b1;
                    mem_addr = {node_q, line_idx};
                    // a fourth beat closes the burst even without last
                    if (req.last || last_line) begin
                        cnt_clear  = 1'b1;
                        state_next = st_idle;
                    end else begin
                        cnt_step = 1'b1;
                    end
                end
            end

            st_read: begin
                mem_en          = 1'b1;
                mem_addr        = {node_q, line_idx};
                edge_tag_valid  = 1'b1;
                edge_tag.sos    = (line_idx == '0);
                edge_tag.eos    = last_line;
                edge_tag.pe_tag = tag_q;
                if (last_line) begin
                    cnt_clear  = 1'b1;
                    state_next = st_idle;
                end else begin
                    cnt_step = 1'b1;
                end
            end

            st_stream: begin
                mem_en               = 1'b1;
                mem_addr             = {iter_q, node_idx, line_idx};
                stream_tag_valid     = 1'b1;
                stream_tag.sos       = (node_idx == '0) && (line_idx == '0);
                stream_tag.eos       = last_line && last_node;
                stream_tag.iter_line = {node_idx, line_idx};
                if (last_line && last_node) begin
                    cnt_clear  = 1'b1;
                    state_next = st_idle;
                end else begin
                    cnt_step = 1'b1;
                end
            end

            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // request fields held for the whole burst
    always_ff @(posedge clk) begin
        if (accept && (state == st_idle)) begin
            node_q <= req.node_id;
            iter_q <= req.iter;
            tag_q  <= req.pe_tag;
        end
    end

    // every burst must start from line 0 of node 0
    a_cnt_zero_in_idle: assert property (@(posedge clk) disable iff (reset)
        (state == st_idle) |-> (line_idx == '0) && (node_idx == '0));

endmodule

//--- rtl/fv_bank_top.sv
// feature-value bank top level
// controller, counter, SRAM and the stream and edge output stages
`timescale 1ns/10ps

module fv_bank_top (
    input  logic                        clk,
    input  logic                        reset,
    input  fv_pkt_pkg::fv_req_t         req,
    input  logic                        req_valid,
    output logic                        req_ready,
    output logic                        stream_valid,
    output fv_pkt_pkg::fv_stream_beat_t stream_beat,
    output logic                        edge_valid,
    output fv_pkt_pkg::fv_edge_beat_t   edge_beat
);

    import fv_cfg_pkg::*;
    import fv_pkt_pkg::*;

    // SRAM access
    logic                 mem_en;
    logic                 mem_we;
    logic [FV_ADDR_W-1:0] mem_addr;
    logic [FV_LINE_W-1:0] mem_wdata;
    logic [FV_LINE_W-1:0] mem_rdata;

    // counter
    logic                      cnt_clear;
    logic                      cnt_step;
    logic [FV_LINE_IDX_W-1:0]  line_idx;
    logic [FV_ITER_NODE_W-1:0] node_idx;
    logic                      last_line;
    logic                      last_node;

    // beat tags issued with each read
    logic            stream_tag_valid;
    fv_stream_beat_t stream_tag;
    logic            edge_tag_valid;
    fv_edge_beat_t   edge_tag;

    fv_bank_fsm i_fsm (
        .clk              (clk),
        .reset            (reset),
        .req              (req),
        .req_valid        (req_valid),
        .line_idx         (line_idx),
        .node_idx         (node_idx),
        .last_line        (last_line),
        .last_node        (last_node),
        .req_ready        (req_ready),
        .mem_en           (mem_en),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .cnt_clear        (cnt_clear),
        .cnt_step         (cnt_step),
        .stream_tag_valid (stream_tag_valid),
        .stream_tag       (stream_tag),
        .edge_tag_valid   (edge_tag_valid),
        .edge_tag         (edge_tag)
    );

    fv_beat_counter i_counter (
        .clk       (clk),
        .reset     (reset),
        .clear     (cnt_clear),
        .step      (cnt_step),
        .line_idx  (line_idx),
        .node_idx  (node_idx),
        .last_line (last_line),
        .last_node (last_node)
    );

    fv_sram i_sram (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    fv_out_stage #(.beat_t(fv_stream_beat_t)) i_stream_stage (
        .clk       (clk),
        .reset     (reset),
        .tag_valid (stream_tag_valid),
        .tag       (stream_tag),
        .rdata     (mem_rdata),
        .out_valid (stream_valid),
        .out_beat  (stream_beat)
    );

    fv_out_stage #(.beat_t(fv_edge_beat_t)) i_edge_stage (
        .clk       (clk),
        .reset     (reset),
        .tag_valid (edge_tag_valid),
        .tag       (edge_tag),
        .rdata     (mem_rdata),
        .out_valid (edge_valid),
        .out_beat  (edge_beat)
    );

endmodule

//--- bench/fv_bank_tb.sv
// testbench for the feature-value bank
// directed write, read and stream tests against a reference line memory
`timescale 1ns/10ps

module fv_bank_tb;

    import fv_cfg_pkg::*;
    import fv_pkt_pkg::*;

    // the tests take about 200 cycles, roughly ten times that is allowed
    localparam int timeout_cycles = 2000;
    localparam int iter_lines     = FV_NODES_PER_ITER * FV_LINES_PER_NODE;

    logic            clk = 1'b0;
    logic            reset;
    fv_req_t         req;
    logic            req_valid;
    logic            req_ready;
    logic            stream_valid;
    fv_stream_beat_t stream_beat;
    logic            edge_valid;
    fv_edge_beat_t   edge_beat;

    // reference copy of every line written
    logic [FV_LINE_W-1:0] ref_mem [FV_DEPTH];

    logic [31:0] rng_state   = 32'h012d90f2;
    int          cycle_count = 0;

    // beats seen on the outputs, with the cycle they showed up in
    fv_edge_beat_t   edge_q[$];
    int              edge_cyc_q[$];
    fv_stream_beat_t stream_q[$];
    int              stream_cyc_q[$];

    fv_bank_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .stream_valid (stream_valid),
        .stream_beat  (stream_beat),
        .edge_valid   (edge_valid),
        .edge_beat    (edge_beat)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            report_failure($sformatf("timeout, the run did not end within %0d cycles",
                                     timeout_cycles));
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (edge_valid) begin
                edge_q.push_back(edge_beat);
                edge_cyc_q.push_back(cycle_count);
            end
            if (stream_valid) begin
                stream_q.push_back(stream_beat);
                stream_cyc_q.push_back(cycle_count);
            end
        end
    end

    task automatic report_failure(input string msg);
        $display("Test failed");
        $fatal(1, "%s", msg);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [FV_LINE_W-1:0] rand_line();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic fv_req_t make_req(input fv_op_t op, input int node, input int iter,
                                         input int tag, input logic [FV_LINE_W-1:0] data,
                                         input logic last);
        fv_req_t r;
        r.op      = op;
        r.node_id = FV_NODE_W'(node);
        r.iter    = FV_ITER_W'(iter);
        r.pe_tag  = FV_PE_TAG_W'(tag);
        r.data    = data;
        r.last    = last;
        return r;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input fv_req_t beat);
        req       = beat;
        req_valid = 1'b1;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic write_node(input int node, input int beats, input bit mark_last);
        logic [FV_LINE_W-1:0] data;
        logic [FV_ADDR_W-1:0] addr;
        for (int i = 0; i < beats; i++) begin
            data          = rand_line();
            addr          = FV_ADDR_W'(node * FV_LINES_PER_NODE + i);
            ref_mem[addr] = data;
            send_req(make_req(op_write, node, 0, 0, data, mark_last && (i == beats - 1)));
        end
    endtask

    task automatic check_edge_burst(input int node, input int tag);
        fv_edge_beat_t        beat;
        int                   cyc;
        int                   first_cyc;
        logic [FV_ADDR_W-1:0] addr;
        first_cyc = 0;
        while (edge_q.size() < FV_LINES_PER_NODE) @(negedge clk);
        for (int i = 0; i < FV_LINES_PER_NODE; i++) begin
            beat = edge_q.pop_front();
            cyc  = edge_cyc_q.pop_front();
            addr = FV_ADDR_W'(node * FV_LINES_PER_NODE + i);
            if (i == 0) begin
                first_cyc = cyc;
            end
            assert (beat.data == ref_mem[addr]) else
                report_failure($sformatf("error edge_beat.data: got 0x%h, expected 0x%h",
                                         beat.data, ref_mem[addr]));
            assert (beat.pe_tag == FV_PE_TAG_W'(tag)) else
                report_failure($sformatf("error edge_beat.pe_tag: got 0x%h, expected 0x%h",
                                         beat.pe_tag, tag));
            assert (beat.sos == (i == 0)) else
                report_failure($sformatf("error edge_beat.sos: got 0x%h on beat 0x%h",
                                         beat.sos, i));
            assert (beat.eos == (i == FV_LINES_PER_NODE - 1)) else
                report_failure($sformatf("error edge_beat.eos: got 0x%h on beat 0x%h",
                                         beat.eos, i));
            assert (cyc == first_cyc + i) else
                report_failure("the beats of an edge burst are not on consecutive cycles");
        end
    endtask

    task automatic read_node(input int node, input int tag);
        send_req(make_req(op_read, node, 0, tag, '0, 1'b0));
        check_edge_burst(node, tag);
    endtask

    task automatic stream_iter(input int iter);
        fv_stream_beat_t      beat;
        int                   cyc;
        int                   first_cyc;
        logic [FV_ADDR_W-1:0] addr;
        send_req(make_req(op_stream, 0, iter, 0, '0, 1'b0));
        while (stream_q.size() < iter_lines) @(negedge clk);
        first_cyc = stream_cyc_q[0];
        for (int j = 0; j < iter_lines; j++) begin
            beat = stream_q.pop_front();
            cyc  = stream_cyc_q.pop_front();
            addr = FV_ADDR_W'(iter * iter_lines + j);
            assert (beat.iter_line == FV_ITER_LINE_W'(j)) else
                report_failure($sformatf("error stream_beat.iter_line: got 0x%h, expected 0x%h",
                                         beat.iter_line, j));
            assert (beat.data == ref_mem[addr]) else
                report_failure($sformatf("error stream_beat.data: got 0x%h, expected 0x%h",
                                         beat.data, ref_mem[addr]));
            assert (beat.sos == (j == 0)) else
                report_failure($sformatf("error stream_beat.sos: got 0x%h on line 0x%h",
                                         beat.sos, j));
            assert (beat.eos == (j == iter_lines - 1)) else
                report_failure($sformatf("error stream_beat.eos: got 0x%h on line 0x%h",
                                         beat.eos, j));
            assert (cyc == first_cyc + j) else
                report_failure("the beats of a stream are not on consecutive cycles");
        end
        repeat (3) @(negedge clk);
        assert (stream_q.size() == 0) else
            report_failure("more stream beats came out than one iteration holds");
        assert (edge_q.size() == 0) else
            report_failure("an edge beat came out during a stream");
    endtask

    task automatic idle_after_reset();
        assert (req_ready === 1'b1) else
            report_failure($sformatf("error req_ready: got 0x%h, expected 0x1", req_ready));
        assert (edge_valid === 1'b0) else
            report_failure($sformatf("error edge_valid: got 0x%h, expected 0x0", edge_valid));
        assert (stream_valid === 1'b0) else
            report_failure($sformatf("error stream_valid: got 0x%h, expected 0x0", stream_valid));
    endtask

    task automatic write_then_read();
        write_node(5, 4, 1'b1);
        read_node(5, 2);
    endtask

    // full burst ended by the fourth beat, then a short one over lines 0 and 1
    task automatic short_burst_keeps_tail();
        write_node(9, 4, 1'b0);
        write_node(9, 2, 1'b1);
        read_node(9, 1);
    endtask

    task automatic stream_after_fill();
        for (int n = 24; n < 32; n++) begin
            write_node(n, 4, 1'b1);
        end
        stream_iter(3);
    endtask

    task automatic reads_back_to_back();
        int nodes [8] = '{5, 24, 9, 31, 27, 5, 30, 25};
        int gap;
        for (int k = 0; k < 8; k++) begin
            gap = int'(next_rand() % 3);
            repeat (gap) @(negedge clk);
            send_req(make_req(op_read, nodes[k], 0, k % 4, '0, 1'b0));
        end
        for (int k = 0; k < 8; k++) begin
            check_edge_burst(nodes[k], k % 4);
        end
        repeat (4) @(negedge clk);
        assert (edge_q.size() == 0) else
            report_failure("extra edge beats came out after the read bursts");
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        idle_after_reset();
        write_then_read();
        short_burst_keeps_tail();
        stream_after_fill();
        reads_back_to_back();
        $display("Test passed");
        $finish;
    end

endmodule

//--- fv_bank_top.f
rtl/fv_cfg_pkg.sv
rtl/fv_pkt_pkg.sv
rtl/fv_sram.sv
rtl/fv_beat_counter.sv
rtl/fv_out_stage.sv
rtl/fv_bank_fsm.sv
rtl/fv_bank_top.sv
bench/fv_bank_tb.sv

//--- Makefile
# Verilator build and run of the feature-value bank testbench

VERILATOR ?= verilator
TOP       ?= fv_bank_tb
FILELIST  ?= fv_bank_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
